// ==== hw/exu_pkg.sv ====
/*
 * Execute stage shared definitions
 * Data and address widths, control enums, the issue and result
 * structs, and the machine CSR addresses used by the trap logic
 */
package exu_pkg;

    localparam int XLEN = 64;
    localparam int PC_W = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [PC_W-1:0] pc_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [11:0]     csr_addr_t;
    typedef logic [7:0]      strb_t;

    // Decode controls
    // --------------------
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_AND,
        ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA
    } alu_op_e;

    typedef enum logic [1:0] {SRC1_RS1, SRC1_PC, SRC1_ZERO} src1_sel_e;

    typedef enum logic [2:0] {
        SRC2_RS2, SRC2_IMM, SRC2_FOUR, SRC2_SHAMT, SRC2_CSR
    } src2_sel_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE,
        BR_BLTU, BR_BGEU, BR_JAL, BR_JALR
    } br_kind_e;

    typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD, MEM_DWORD} mem_size_e;

    typedef enum logic [1:0] {CSR_NONE, CSR_WRITE, CSR_SET, CSR_CLEAR} csr_op_e;

    typedef enum logic [1:0] {
        TRAP_IDLE, TRAP_WRITE_MEPC, TRAP_WRITE_MCAUSE
    } trap_state_e;

    // Machine CSRs
    // --------------------
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;

    localparam xlen_t CAUSE_ECALL_M = 64'd11;

    // Stage structs
    // --------------------
    typedef struct packed {
        alu_op_e   op;
        src1_sel_e src1_sel;
        src2_sel_e src2_sel;
        br_kind_e  br_kind;
        xlen_t     imm;
        xlen_t     rs1_value;
        xlen_t     rs2_value;
        pc_t       pc;
        reg_idx_t  rd;
        logic      rf_we;
        logic      mem_re;
        logic      mem_we;
        mem_size_e mem_size;
        csr_op_e   csr_op;
        csr_addr_t csr_addr;
        logic      is_ecall;
        logic      is_mret;
        logic      pred_taken;
        pc_t       pred_target;
    } exu_issue_t;

    typedef struct packed {
        pc_t       pc;
        reg_idx_t  rd;
        logic      rf_we;
        xlen_t     result;
        logic      mem_re;
        logic      mem_we;
        mem_size_e mem_size;
        logic [2:0] addr_offset;
    } exu_result_t;

    typedef struct packed {
        logic flush;
        pc_t  target;
    } redirect_t;

endpackage

// ==== hw/exu_alu.sv ====
/*
 * Integer ALU
 * Selects both operands from the decode controls and computes
 * one of the ten integer operations
 */
`timescale 1ns/1ns

module exu_alu (
    input  exu_pkg::exu_issue_t issue_i,
    input  exu_pkg::xlen_t      csr_rdata_i,
    output exu_pkg::xlen_t      result_o
);

    exu_pkg::xlen_t src1;
    exu_pkg::xlen_t src2;
    logic [5:0]     shamt;

    // Operand select
    // --------------------
    always_comb begin
        case (issue_i.src1_sel)
            exu_pkg::SRC1_PC: begin
                src1 = {{(exu_pkg::XLEN-exu_pkg::PC_W){1'b0}}, issue_i.pc};
            end
            exu_pkg::SRC1_ZERO: begin
                src1 = '0;
            end
            default: begin
                src1 = issue_i.rs1_value;
            end
        endcase
    end

    always_comb begin
        case (issue_i.src2_sel)
            exu_pkg::SRC2_IMM: begin
                src2 = issue_i.imm;
            end
            exu_pkg::SRC2_FOUR: begin
                src2 = 64'd4;
            end
            exu_pkg::SRC2_SHAMT: begin
                src2 = {58'b0, issue_i.imm[5:0]};
            end
            exu_pkg::SRC2_CSR: begin
                src2 = csr_rdata_i;
            end
            default: begin
                src2 = issue_i.rs2_value;
            end
        endcase
    end

    assign shamt = src2[5:0];

    // Operations
    // --------------------
    always_comb begin
        case (issue_i.op)
            exu_pkg::ALU_SUB:  result_o = src1 - src2;
            exu_pkg::ALU_SLT:  result_o = {63'b0, $signed(src1) < $signed(src2)};
            exu_pkg::ALU_SLTU: result_o = {63'b0, src1 < src2};
            exu_pkg::ALU_AND:  result_o = src1 & src2;
            exu_pkg::ALU_OR:   result_o = src1 | src2;
            exu_pkg::ALU_XOR:  result_o = src1 ^ src2;
            exu_pkg::ALU_SLL:  result_o = src1 << shamt;
            exu_pkg::ALU_SRL:  result_o = src1 >> shamt;
            exu_pkg::ALU_SRA:  result_o = $signed(src1) >>> shamt;
            default:           result_o = src1 + src2;
        endcase
    end

endmodule

// ==== hw/exu_branch_check.sv ====
/*
 * Branch and jump resolution
 * Evaluates the real outcome and target and flags a mismatch
 * with the front end prediction
 */
`timescale 1ns/1ns

module exu_branch_check (
    input  exu_pkg::exu_issue_t issue_i,
    input  logic                stage_valid_i,
    output logic                mispredict_o,
    output exu_pkg::pc_t        fix_pc_o
);

    logic           eq;
    logic           lt;
    logic           ltu;
    logic           taken;
    exu_pkg::xlen_t jalr_sum;
    exu_pkg::pc_t   target;

    assign eq  = issue_i.rs1_value == issue_i.rs2_value;
    assign lt  = $signed(issue_i.rs1_value) < $signed(issue_i.rs2_value);
    assign ltu = issue_i.rs1_value < issue_i.rs2_value;

    always_comb begin
        case (issue_i.br_kind)
            exu_pkg::BR_BEQ:  taken = eq;
            exu_pkg::BR_BNE:  taken = !eq;
            exu_pkg::BR_BLT:  taken = lt;
            exu_pkg::BR_BGE:  taken = !lt;
            exu_pkg::BR_BLTU: taken = ltu;
            exu_pkg::BR_BGEU: taken = !ltu;
            exu_pkg::BR_JAL:  taken = 1'b1;
            exu_pkg::BR_JALR: taken = 1'b1;
            default:          taken = 1'b0;
        endcase
    end

    assign jalr_sum = issue_i.rs1_value + issue_i.imm;
    assign target   = (issue_i.br_kind == exu_pkg::BR_JALR)
                    ? {jalr_sum[exu_pkg::PC_W-1:1], 1'b0}
                    : issue_i.pc + issue_i.imm[exu_pkg::PC_W-1:0];

    // Wrong direction, or right direction with a stale target
    assign mispredict_o = stage_valid_i && (issue_i.br_kind != exu_pkg::BR_NONE)
                       && ((taken != issue_i.pred_taken)
                       || (taken && (target != issue_i.pred_target)));

    assign fix_pc_o = taken ? target : issue_i.pc + 32'd4;

endmodule

// ==== hw/exu_csr_trap.sv ====
/*
 * Machine CSR file and trap sequencer
 * Holds mtvec, mepc, mcause and mscratch, performs CSR
 * read-modify-write and writes mepc then mcause after an ecall
 */
`timescale 1ns/1ns

module exu_csr_trap #(
    parameter exu_pkg::xlen_t MSCRATCH_RESET = '0
) (
    input  logic                clk,
    input  logic                reset,
    input  exu_pkg::exu_issue_t issue_i,
    input  logic                stage_valid_i,
    input  logic                leave_i,
    output exu_pkg::xlen_t      csr_rdata_o,
    output logic                trap_flush_o,
    output exu_pkg::pc_t        trap_pc_o,
    output logic                busy_o
);

    exu_pkg::xlen_t       mtvec;
    exu_pkg::xlen_t       mepc;
    exu_pkg::xlen_t       mcause;
    exu_pkg::xlen_t       mscratch;
    exu_pkg::xlen_t       csr_wdata;
    logic                 csr_we;
    logic                 ecall_leave;
    exu_pkg::trap_state_e trap_state;
    exu_pkg::pc_t         trap_pc_r;

    always_comb begin
        case (issue_i.csr_addr)
            exu_pkg::CSR_MTVEC:    csr_rdata_o = mtvec;
            exu_pkg::CSR_MEPC:     csr_rdata_o = mepc;
            exu_pkg::CSR_MCAUSE:   csr_rdata_o = mcause;
            exu_pkg::CSR_MSCRATCH: csr_rdata_o = mscratch;
            default:               csr_rdata_o = '0;
        endcase
    end

    always_comb begin
        case (issue_i.csr_op)
            exu_pkg::CSR_SET:   csr_wdata = csr_rdata_o | issue_i.rs1_value;
            exu_pkg::CSR_CLEAR: csr_wdata = csr_rdata_o & ~issue_i.rs1_value;
            default:            csr_wdata = issue_i.rs1_value;
        endcase
    end

    assign csr_we      = leave_i && (issue_i.csr_op != exu_pkg::CSR_NONE);
    assign ecall_leave = leave_i && issue_i.is_ecall;

    always_ff @(posedge clk) begin
        if (reset) begin
            mtvec    <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mscratch <= MSCRATCH_RESET;
        end else begin
            if (csr_we) begin
                case (issue_i.csr_addr)
                    exu_pkg::CSR_MTVEC:    mtvec    <= csr_wdata;
                    exu_pkg::CSR_MEPC:     mepc     <= csr_wdata;
                    exu_pkg::CSR_MCAUSE:   mcause   <= csr_wdata;
                    exu_pkg::CSR_MSCRATCH: mscratch <= csr_wdata;
                    default: ;
                endcase
            end
            // Trap writes last so they override a CSR instruction
            if (trap_state == exu_pkg::TRAP_WRITE_MEPC) begin
                mepc <= {{(exu_pkg::XLEN-exu_pkg::PC_W){1'b0}}, trap_pc_r};
            end
            if (trap_state == exu_pkg::TRAP_WRITE_MCAUSE) begin
                mcause <= exu_pkg::CAUSE_ECALL_M;
            end
        end
    end

    // Trap sequencer
    // --------------------
    always_ff @(posedge clk) begin
        if (ecall_leave) begin
            trap_pc_r <= issue_i.pc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            trap_state <= exu_pkg::TRAP_IDLE;
        end else begin
            case (trap_state)
                exu_pkg::TRAP_WRITE_MEPC: trap_state <= exu_pkg::TRAP_WRITE_MCAUSE;
                default: begin
                    trap_state <= ecall_leave ? exu_pkg::TRAP_WRITE_MEPC
                                              : exu_pkg::TRAP_IDLE;
                end
            endcase
        end
    end

    assign busy_o       = trap_state == exu_pkg::TRAP_WRITE_MEPC;
    assign trap_flush_o = stage_valid_i && (issue_i.is_ecall || issue_i.is_mret);
    assign trap_pc_o    = issue_i.is_ecall ? mtvec[exu_pkg::PC_W-1:0]
                                           : mepc[exu_pkg::PC_W-1:0];

endmodule

// ==== hw/exu_store_align.sv ====
/*
 * Store lane alignment
 * Builds byte strobes for the access size and offset, and moves
 * the store data into its byte lane
 */
`timescale 1ns/1ns

module exu_store_align (
    input  exu_pkg::exu_issue_t issue_i,
    input  exu_pkg::xlen_t      addr_i,
    input  logic                stage_valid_i,
    output exu_pkg::strb_t      wstrb_o,
    output exu_pkg::xlen_t      wdata_o,
    output logic [2:0]          offset_o
);

    exu_pkg::strb_t strb;

    assign offset_o = addr_i[2:0];

    // Halves and words snap to their natural lane
    always_comb begin
        case (issue_i.mem_size)
            exu_pkg::MEM_BYTE:  strb = 8'h01 << offset_o;
            exu_pkg::MEM_HALF:  strb = 8'h03 << {offset_o[2:1], 1'b0};
            exu_pkg::MEM_WORD:  strb = 8'h0f << {offset_o[2], 2'b00};
            default:            strb = 8'hff;
        endcase
    end

    assign wstrb_o = (stage_valid_i && issue_i.mem_we) ? strb : '0;
    assign wdata_o = issue_i.rs2_value << {offset_o, 3'b000};

endmodule

// ==== hw/exu_top.sv ====
/*
 * Execute stage top
 * Holds one issued instruction behind a valid/allowin handshake,
 * computes its result, resolves branches and traps, and drives
 * the data memory request
 */
`timescale 1ns/1ns

module exu_top #(
    parameter exu_pkg::xlen_t MSCRATCH_RESET = '0
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 in_valid_i,
    input  exu_pkg::exu_issue_t  issue_i,
    output logic                 in_allowin_o,
    output logic                 out_valid_o,
    input  logic                 out_ready_i,
    output exu_pkg::exu_result_t result_o,
    output exu_pkg::redirect_t   redirect_o,
    output logic                 data_en_o,
    output exu_pkg::strb_t       data_wstrb_o,
    output exu_pkg::pc_t         data_addr_o,
    output exu_pkg::xlen_t       data_wdata_o
);

    logic                stage_valid;
    exu_pkg::exu_issue_t issue_r;
    logic                ready_go;
    logic                leave;

    exu_pkg::xlen_t alu_result;
    exu_pkg::xlen_t csr_rdata;
    logic           mispredict;
    exu_pkg::pc_t   fix_pc;
    logic           trap_flush;
    exu_pkg::pc_t   trap_pc;
    logic           trap_busy;
    logic [2:0]     addr_offset;

    // Stage register
    // --------------------
    // Held back for one cycle while the trap writes mepc
    assign ready_go     = !trap_busy;
    assign in_allowin_o = !stage_valid || (ready_go && out_ready_i);
    assign out_valid_o  = stage_valid && ready_go && !trap_flush;
    assign leave        = stage_valid && ready_go && out_ready_i;

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= 1'b0;
        end else if (in_allowin_o) begin
            stage_valid <= in_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid_i && in_allowin_o) begin
            issue_r <= issue_i;
        end
    end

    exu_alu u_alu (
        .issue_i     (issue_r),
        .csr_rdata_i (csr_rdata),
        .result_o    (alu_result)
    );

    exu_branch_check u_branch_check (
        .issue_i       (issue_r),
        .stage_valid_i (stage_valid),
        .mispredict_o  (mispredict),
        .fix_pc_o      (fix_pc)
    );

    exu_csr_trap #(
        .MSCRATCH_RESET (MSCRATCH_RESET)
    ) u_csr_trap (
        .clk           (clk),
        .reset         (reset),
        .issue_i       (issue_r),
        .stage_valid_i (stage_valid),
        .leave_i       (leave),
        .csr_rdata_o   (csr_rdata),
        .trap_flush_o  (trap_flush),
        .trap_pc_o     (trap_pc),
        .busy_o        (trap_busy)
    );

    exu_store_align u_store_align (
        .issue_i       (issue_r),
        .addr_i        (alu_result),
        .stage_valid_i (stage_valid),
        .wstrb_o       (data_wstrb_o),
        .wdata_o       (data_wdata_o),
        .offset_o      (addr_offset)
    );

    // Mispredict wins, a branch is never also a CSR instruction
    assign redirect_o.flush  = mispredict || trap_flush;
    assign redirect_o.target = mispredict ? fix_pc : trap_pc;

    assign data_en_o   = stage_valid && (issue_r.mem_re || issue_r.mem_we) && out_ready_i;
    assign data_addr_o = alu_result[exu_pkg::PC_W-1:0];

    assign result_o.pc          = issue_r.pc;
    assign result_o.rd          = issue_r.rd;
    assign result_o.rf_we       = issue_r.rf_we;
    assign result_o.result      = alu_result;
    assign result_o.mem_re      = issue_r.mem_re;
    assign result_o.mem_we      = issue_r.mem_we;
    assign result_o.mem_size    = issue_r.mem_size;
    assign result_o.addr_offset = addr_offset;

endmodule

// ==== verification/exu_checker.sv ====
/*
 * Execute stage checker
 * Watches the DUT ports each rising edge and compares them with
 * the expected values of the instruction held in the stage
 */
`timescale 1ns/1ns

module exu_checker (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 check_en_i,
    input  logic                 exp_allowin_i,
    input  logic                 exp_out_valid_i,
    input  logic                 exp_check_result_i,
    input  logic                 exp_mem_i,
    input  logic                 exp_store_i,
    input  exu_pkg::exu_issue_t  exp_issue_i,
    input  exu_pkg::xlen_t       exp_result_i,
    input  logic                 exp_flush_i,
    input  exu_pkg::pc_t         exp_target_i,
    input  exu_pkg::strb_t       exp_strb_i,
    input  exu_pkg::xlen_t       exp_wdata_i,
    input  logic                 in_allowin_i,
    input  logic                 out_valid_i,
    input  logic                 out_ready_i,
    input  exu_pkg::exu_result_t result_i,
    input  exu_pkg::redirect_t   redirect_i,
    input  logic                 data_en_i,
    input  exu_pkg::strb_t       data_wstrb_i,
    input  exu_pkg::pc_t         data_addr_i,
    input  exu_pkg::xlen_t       data_wdata_i,
    output int                   error_count_o,
    output int                   check_count_o
);

    int errors = 0;
    int checks = 0;

    task automatic check_value(input string what, input exu_pkg::xlen_t got,
                               input exu_pkg::xlen_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            check_value("in_allowin", in_allowin_i, exp_allowin_i);
            if (check_en_i) begin
                check_value("out_valid", out_valid_i, exp_out_valid_i);
                check_value("flush", redirect_i.flush, exp_flush_i);
                if (exp_flush_i) begin
                    check_value("flush target", redirect_i.target, exp_target_i);
                end
                check_value("data_en", data_en_i, exp_mem_i && out_ready_i);
                check_value("write strobes", data_wstrb_i, exp_strb_i);
                if (exp_store_i) begin
                    check_value("write data", data_wdata_i, exp_wdata_i);
                end
                if (exp_mem_i) begin
                    check_value("data address", data_addr_i,
                                exp_result_i[exu_pkg::PC_W-1:0]);
                    check_value("address offset", result_i.addr_offset, exp_result_i[2:0]);
                end
                // Held steady under back-pressure, so checked every cycle
                if (exp_out_valid_i && exp_check_result_i) begin
                    check_value("result", result_i.result, exp_result_i);
                end
                if (exp_out_valid_i) begin
                    check_value("result pc", result_i.pc, exp_issue_i.pc);
                    check_value("result rd", result_i.rd, exp_issue_i.rd);
                    check_value("result controls",
                                {result_i.rf_we, result_i.mem_re, result_i.mem_we,
                                 result_i.mem_size},
                                {exp_issue_i.rf_we, exp_issue_i.mem_re, exp_issue_i.mem_we,
                                 exp_issue_i.mem_size});
                end
            end else begin
                check_value("empty stage out_valid", out_valid_i, 1'b0);
                check_value("empty stage flush", redirect_i.flush, 1'b0);
                check_value("empty stage data_en", data_en_i, 1'b0);
                check_value("empty stage strobes", data_wstrb_i, 8'h00);
            end
        end
    end

    assign error_count_o = errors;
    assign check_count_o = checks;

endmodule

// ==== verification/tb_exu.sv ====
/*
 * Execute stage testbench
 * Streams a table of instructions through the stage under random
 * back-pressure and hands the expected outputs to the checker
 */
`timescale 1ns/1ns

module tb_exu;

    typedef struct packed {
        exu_pkg::exu_issue_t iss;
        exu_pkg::xlen_t      result;
        logic                flush;
        exu_pkg::pc_t        target;
        exu_pkg::strb_t      strb;
        exu_pkg::xlen_t      wdata;
    } entry_t;

    logic                 clk;
    logic                 reset;
    logic                 in_valid;
    exu_pkg::exu_issue_t  issue;
    logic                 in_allowin;
    logic                 out_valid;
    logic                 out_ready;
    exu_pkg::exu_result_t result;
    exu_pkg::redirect_t   redirect;
    logic                 data_en;
    exu_pkg::strb_t       data_wstrb;
    exu_pkg::pc_t         data_addr;
    exu_pkg::xlen_t       data_wdata;

    entry_t table_q[$];
    entry_t stage_e;
    entry_t exp_e;
    logic   stage_full;
    logic   busy_exp;
    logic   chk_en;
    logic   exp_allowin;
    logic   exp_out_valid;
    int     error_count;
    int     check_count;
    int     timeouts;

    function automatic exu_pkg::exu_issue_t base_issue(exu_pkg::alu_op_e op,
            exu_pkg::src1_sel_e s1, exu_pkg::src2_sel_e s2, exu_pkg::xlen_t imm,
            exu_pkg::xlen_t rs1, exu_pkg::xlen_t rs2);
        exu_pkg::exu_issue_t i;
        i           = '0;
        i.op        = op;
        i.src1_sel  = s1;
        i.src2_sel  = s2;
        i.imm       = imm;
        i.rs1_value = rs1;
        i.rs2_value = rs2;
        i.rd        = 5'd5;
        i.rf_we     = 1'b1;
        return i;
    endfunction

    // Link value pc + 4 comes out of the ALU for jumps
    function automatic exu_pkg::exu_issue_t branch_issue(exu_pkg::br_kind_e kind,
            exu_pkg::pc_t pc, exu_pkg::xlen_t imm, exu_pkg::xlen_t rs1,
            exu_pkg::xlen_t rs2, logic pred_taken, exu_pkg::pc_t pred_target);
        exu_pkg::exu_issue_t i;
        i = base_issue(exu_pkg::ALU_ADD, exu_pkg::SRC1_PC, exu_pkg::SRC2_FOUR, imm, rs1, rs2);
        i.br_kind     = kind;
        i.pc          = pc;
        i.rf_we       = (kind == exu_pkg::BR_JAL) || (kind == exu_pkg::BR_JALR);
        i.pred_taken  = pred_taken;
        i.pred_target = pred_target;
        return i;
    endfunction

    function automatic exu_pkg::exu_issue_t mem_issue(logic store,
            exu_pkg::mem_size_e size, exu_pkg::xlen_t offset);
        exu_pkg::exu_issue_t i;
        i = base_issue(exu_pkg::ALU_ADD, exu_pkg::SRC1_RS1, exu_pkg::SRC2_IMM, offset,
                       64'h8000, 64'h1122_3344_5566_7788);
        i.rf_we    = !store;
        i.mem_re   = !store;
        i.mem_we   = store;
        i.mem_size = size;
        return i;
    endfunction

    function automatic exu_pkg::exu_issue_t csr_issue(exu_pkg::csr_op_e op,
            exu_pkg::csr_addr_t addr, exu_pkg::xlen_t rs1);
        exu_pkg::exu_issue_t i;
        i = base_issue(exu_pkg::ALU_ADD, exu_pkg::SRC1_ZERO, exu_pkg::SRC2_CSR, 0, rs1, 0);
        i.csr_op   = op;
        i.csr_addr = addr;
        return i;
    endfunction

    function automatic exu_pkg::exu_issue_t trap_issue(logic ecall, exu_pkg::pc_t pc);
        exu_pkg::exu_issue_t i;
        i          = '0;
        i.is_ecall = ecall;
        i.is_mret  = !ecall;
        i.pc       = pc;
        return i;
    endfunction

    task automatic add_entry(exu_pkg::exu_issue_t iss, exu_pkg::xlen_t res, logic flush,
            exu_pkg::pc_t target, exu_pkg::strb_t strb, exu_pkg::xlen_t wdata);
        entry_t e;
        e.iss    = iss;
        e.result = res;
        e.flush  = flush;
        e.target = target;
        e.strb   = strb;
        e.wdata  = wdata;
        table_q.push_back(e);
    endtask

    // Stimulus table
    // --------------------
    task automatic build_table();
        add_entry(base_issue(exu_pkg::ALU_ADD, exu_pkg::SRC1_RS1, exu_pkg::SRC2_RS2, 0, 100, 23),
                  64'd123, 0, 0, 0, 0);
        add_entry(base_issue(exu_pkg::ALU_SUB, exu_pkg::SRC1_RS1, exu_pkg::SRC2_RS2, 0, 5, 7),
                  64'hFFFF_FFFF_FFFF_FFFE, 0, 0, 0, 0);
        add_entry(base_issue(exu_pkg::ALU_SLT, exu_pkg::SRC1_RS1, exu_pkg::SRC2_RS2, 0,
                  64'hFFFF_FFFF_FFFF_FFFF, 1), 64'd1, 0, 0, 0, 0);
        add_entry(base_issue(exu_pkg::ALU_SLTU, exu_pkg::SRC1_RS1, exu_pkg::SRC2_RS2, 0,
                  64'hFFFF_FFFF_FFFF_FFFF, 1), 64'd0, 0, 0, 0, 0);
        add_entry(base_issue(exu_pkg::ALU_AND, exu_pkg::SRC1_RS1, exu_pkg::SRC2_IMM,
                  64'hFF00, 64'hF0F0, 0), 64'hF000, 0, 0, 0, 0);
        add_entry(base_issue(exu_pkg::ALU_OR, exu_pkg::SRC1_RS1, exu_pkg::SRC2_RS2, 0,
                  64'hF0F0, 64'h0F0F), 64'hFFFF, 0, 0, 0, 0);
        add_entry(base_issue(exu_pkg::ALU_XOR, exu_pkg::SRC1_RS1, exu_pkg::SRC2_IMM,
                  64'h0F, 64'hFF, 0), 64'hF0, 0, 0, 0, 0);
        add_entry(base_issue(exu_pkg::ALU_SLL, exu_pkg::SRC1_RS1, exu_pkg::SRC2_SHAMT,
                  63, 1, 0), 64'h8000_0000_0000_0000, 0, 0, 0, 0);
        add_entry(base_issue(exu_pkg::ALU_SRL, exu_pkg::SRC1_RS1, exu_pkg::SRC2_SHAMT,
                  4, 64'h8000_0000_0000_0000, 0), 64'h0800_0000_0000_0000, 0, 0, 0, 0);
        add_entry(base_issue(exu_pkg::ALU_SRA, exu_pkg::SRC1_RS1, exu_pkg::SRC2_RS2,
                  0, 64'h8000_0000_0000_0000, 4), 64'hF800_0000_0000_0000, 0, 0, 0, 0);
        // Branches and jumps
        add_entry(branch_issue(exu_pkg::BR_BEQ, 32'h200, 16, 5, 5, 1, 32'h210),
                  0, 0, 0, 0, 0);
        add_entry(branch_issue(exu_pkg::BR_BNE, 32'h220, 16, 5, 5, 1, 32'h300),
                  0, 1, 32'h224, 0, 0);
        add_entry(branch_issue(exu_pkg::BR_BLT, 32'h240, 64'hFFFF_FFFF_FFFF_FFF0,
                  64'hFFFF_FFFF_FFFF_FFFD, 2, 0, 0), 0, 1, 32'h230, 0, 0);
        add_entry(branch_issue(exu_pkg::BR_BGEU, 32'h260, 64'h40, 5, 2, 1, 32'h2B0),
                  0, 1, 32'h2A0, 0, 0);
        add_entry(branch_issue(exu_pkg::BR_JAL, 32'h280, 64'h100, 0, 0, 1, 32'h380),
                  64'h284, 0, 0, 0, 0);
        add_entry(branch_issue(exu_pkg::BR_JALR, 32'h2A0, 64'h10, 64'h1003, 0, 0, 0),
                  64'h2A4, 1, 32'h1012, 0, 0);
        // Stores at several sizes and offsets, then a load
        add_entry(mem_issue(1, exu_pkg::MEM_BYTE, 3), 64'h8003, 0, 0, 8'h08,
                  64'h4455_6677_8800_0000);
        add_entry(mem_issue(1, exu_pkg::MEM_HALF, 3), 64'h8003, 0, 0, 8'h0C,
                  64'h4455_6677_8800_0000);
        add_entry(mem_issue(1, exu_pkg::MEM_WORD, 4), 64'h8004, 0, 0, 8'hF0,
                  64'h5566_7788_0000_0000);
        add_entry(mem_issue(1, exu_pkg::MEM_DWORD, 0), 64'h8000, 0, 0, 8'hFF,
                  64'h1122_3344_5566_7788);
        add_entry(mem_issue(0, exu_pkg::MEM_WORD, 4), 64'h8004, 0, 0, 8'h00, 0);
        // CSR read-modify-write returns the old value
        add_entry(csr_issue(exu_pkg::CSR_WRITE, exu_pkg::CSR_MSCRATCH, 64'h55AA), 0, 0, 0, 0, 0);
        add_entry(csr_issue(exu_pkg::CSR_SET, exu_pkg::CSR_MSCRATCH, 64'h0F00),
                  64'h55AA, 0, 0, 0, 0);
        add_entry(csr_issue(exu_pkg::CSR_CLEAR, exu_pkg::CSR_MSCRATCH, 64'h00AA),
                  64'h5FAA, 0, 0, 0, 0);
        add_entry(csr_issue(exu_pkg::CSR_NONE, exu_pkg::CSR_MSCRATCH, 0), 64'h5F00, 0, 0, 0, 0);
        add_entry(csr_issue(exu_pkg::CSR_WRITE, exu_pkg::CSR_MTVEC, 64'h8000_0100),
                  0, 0, 0, 0, 0);
        // Trap entry and return
        add_entry(trap_issue(1, 32'h400), 0, 1, 32'h8000_0100, 0, 0);
        add_entry(csr_issue(exu_pkg::CSR_NONE, exu_pkg::CSR_MEPC, 0), 64'h400, 0, 0, 0, 0);
        add_entry(csr_issue(exu_pkg::CSR_NONE, exu_pkg::CSR_MCAUSE, 0), 64'd11, 0, 0, 0, 0);
        add_entry(trap_issue(0, 32'h500), 0, 1, 32'h400, 0, 0);
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        int   idx;
        int   stall;
        int   seed_val;
        logic ecall_left;
        reset         = 1'b1;
        in_valid      = 1'b0;
        issue         = '0;
        out_ready     = 1'b0;
        chk_en        = 1'b0;
        exp_allowin   = 1'b1;
        exp_out_valid = 1'b0;
        exp_e         = '0;
        stage_e       = '0;
        stage_full    = 1'b0;
        busy_exp      = 1'b0;
        timeouts      = 0;
        idx           = 0;
        stall         = 0;
        seed_val      = $urandom(32'h03929cb6);
        build_table();
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // Drive on the falling edge, track the stage on the rising edge
        while ((idx < table_q.size() || stage_full) && timeouts == 0) begin
            out_ready = ($urandom % 4) != 0;
            in_valid  = idx < table_q.size();
            if (in_valid) begin
                issue = table_q[idx].iss;
            end
            chk_en        = stage_full;
            exp_e         = stage_e;
            exp_allowin   = !stage_full || (!busy_exp && out_ready);
            exp_out_valid = stage_full && !stage_e.iss.is_ecall && !stage_e.iss.is_mret
                            && !busy_exp;
            @(posedge clk);
            ecall_left = in_allowin && stage_full && stage_e.iss.is_ecall;
            if (in_allowin) begin
                stage_full = in_valid;
                if (in_valid) begin
                    stage_e = table_q[idx];
                    idx++;
                end
                stall = 0;
            end else begin
                stall++;
            end
            busy_exp = ecall_left;
            if (stall > 50) begin
                $display("Timeout: the stage held one instruction for more than 50 cycles");
                timeouts++;
            end
            @(negedge clk);
        end

        chk_en      = 1'b0;
        in_valid    = 1'b0;
        exp_allowin = 1'b1;
        @(negedge clk);
        $display("Checks: %0d, errors: %0d, timeouts: %0d", check_count, error_count, timeouts);
        if (error_count == 0 && timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    exu_top u_dut (
        .clk          (clk),
        .reset        (reset),
        .in_valid_i   (in_valid),
        .issue_i      (issue),
        .in_allowin_o (in_allowin),
        .out_valid_o  (out_valid),
        .out_ready_i  (out_ready),
        .result_o     (result),
        .redirect_o   (redirect),
        .data_en_o    (data_en),
        .data_wstrb_o (data_wstrb),
        .data_addr_o  (data_addr),
        .data_wdata_o (data_wdata)
    );

    exu_checker u_checker (
        .clk                (clk),
        .reset              (reset),
        .check_en_i         (chk_en),
        .exp_allowin_i      (exp_allowin),
        .exp_out_valid_i    (exp_out_valid),
        .exp_check_result_i (exp_e.iss.rf_we || exp_e.iss.mem_re || exp_e.iss.mem_we),
        .exp_mem_i          (exp_e.iss.mem_re || exp_e.iss.mem_we),
        .exp_store_i        (exp_e.iss.mem_we),
        .exp_issue_i        (exp_e.iss),
        .exp_result_i       (exp_e.result),
        .exp_flush_i        (exp_e.flush),
        .exp_target_i       (exp_e.target),
        .exp_strb_i         (exp_e.strb),
        .exp_wdata_i        (exp_e.wdata),
        .in_allowin_i       (in_allowin),
        .out_valid_i        (out_valid),
        .out_ready_i        (out_ready),
        .result_i           (result),
        .redirect_i         (redirect),
        .data_en_i          (data_en),
        .data_wstrb_i       (data_wstrb),
        .data_addr_i        (data_addr),
        .data_wdata_i       (data_wdata),
        .error_count_o      (error_count),
        .check_count_o      (check_count)
    );

endmodule

// ==== list.f ====
hw/exu_pkg.sv
hw/exu_alu.sv
hw/exu_branch_check.sv
hw/exu_csr_trap.sv
hw/exu_store_align.sv
hw/exu_top.sv
verification/exu_checker.sv
verification/tb_exu.sv
